// File: list.f
+incdir+.
stmcu_video_pkg.sv
mcu_clock_enables.sv
video_regs.sv
hsync_gen.sv
vsync_gen.sv
de_gen.sv
vid_interrupts.sv
stmcu_video.sv
tb_stmcu_video.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video timing testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_stmcu_video -f list.f -o tb_stmcu_video > build.log 2>&1 \
    && ./obj_dir/tb_stmcu_video > sim.log 2>&1
# The log decides the result, whatever the exit codes above were
grep -q "Everything OK" sim.log 2>/dev/null \
    && echo "PASS, see sim.log" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: tb_bus_tasks.svh
/*
 * Testbench helpers for the video timing block
 *  - CPU bus write, read and interrupt acknowledge cycles
 *  - Sync level waits with timeout, period and width measurement
 */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// All strobes high
task automatic release_bus();
    bus_i <= '{as_n: 1'b1, rw: 1'b1, uds_n: 1'b1, lds_n: 1'b1,
               fc: 3'd0, addr: 23'd0, wdata: 16'd0};
endtask

// One word cycle, outputs sampled mid-cycle while the strobes are low
task automatic cpu_access(input logic rw, input logic [2:0] fc, input logic [23:1] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata,
                          output logic oe_n, output logic dtack_n, output logic vpa_n);
    @(posedge clk32);
    bus_i <= '{as_n: 1'b0, rw: rw, uds_n: 1'b0, lds_n: 1'b0,
               fc: fc, addr: addr, wdata: wdata};
    @(negedge clk32);
    rdata   = rdata_o;
    oe_n    = oe_h_n_o;
    dtack_n = dtack_n_o;
    vpa_n   = vpa_n_o;
    @(posedge clk32);                      // Registers latch on this edge
    release_bus();
endtask

task automatic cpu_write(input logic [2:0] fc, input logic [23:1] addr,
                         input logic [15:0] data, output logic dtack_n);
    logic [15:0] rd;
    logic        oe_n;
    logic        vpa_n;
    cpu_access(1'b0, fc, addr, data, rd, oe_n, dtack_n, vpa_n);
endtask

task automatic cpu_read(input logic [2:0] fc, input logic [23:1] addr,
                        output logic [15:0] rdata, output logic oe_n, output logic dtack_n);
    logic vpa_n;
    cpu_access(1'b1, fc, addr, 16'd0, rdata, oe_n, dtack_n, vpa_n);
endtask

// Autovectored acknowledge, level code on A3..A1
task automatic int_ack(input logic [2:0] level, output logic vpa_n);
    logic [15:0] rd;
    logic        oe_n;
    logic        dtack_n;
    cpu_access(1'b1, FC_IACK, {20'hFFFFF, level}, 16'd0, rd, oe_n, dtack_n, vpa_n);
endtask

// ======================================================================
// Sync waits, counted in clk32 cycles on the falling clock edge
// ======================================================================
task automatic wait_sync(input logic vert, input logic level, input int limit,
                         output int cycles);
    cycles = 0;
    while ((vert ? vsync_n_o : hsync_n_o) !== level) begin
        @(negedge clk32);
        cycles++;
        if (cycles > limit)
            stop_on_error($sformatf("Timeout waiting for %s to become %b",
                                    vert ? "vsync_n_o" : "hsync_n_o", level));
    end
endtask

// Skips one pulse so that a mode change has settled
task automatic measure_sync(input logic vert, input int limit, output int low,
                            output int period);
    int skip;
    int high;
    @(negedge clk32);
    wait_sync(vert, 1'b1, limit, skip);
    wait_sync(vert, 1'b0, limit, skip);
    wait_sync(vert, 1'b1, limit, skip);
    wait_sync(vert, 1'b0, limit, skip);
    wait_sync(vert, 1'b1, limit, low);     // Low width
    wait_sync(vert, 1'b0, limit, high);
    period = low + high;
endtask

`endif

// File: tb_stmcu_video.sv
/*
 * Testbench for the STe video timing block
 *  - Reset state and register access
 *  - Horizontal and vertical sync timing per mode
 *  - HBL, VBL and MFP interrupt priority
 */
`timescale 1ns/100ps
`default_nettype none

module tb_stmcu_video;

    import stmcu_video_pkg::*;

    localparam int HSYNC_LIMIT = 4000;
    localparam int VSYNC_LIMIT = 800000;   // Longer than a PAL frame
    localparam int LINE_NTSC   = 127 * 16; // Ticks per line times clk32 per tick
    localparam int LINE_PAL    = 128 * 16;
    localparam int LINE_MONO   = 56 * 16;

    logic        clk32;
    logic        porb;
    cpu_bus_t    bus_i;
    logic        mfpint_n_i;
    logic [15:0] rdata_o;
    logic        oe_h_n_o, dtack_n_o, vpa_n_o;
    logic        ipl1_n_o, ipl2_n_o;
    logic        hsync_n_o, vsync_n_o;
    logic        de_o, blank_n_o;

    stmcu_video #(.TICK_DIV(16)) stmcu_video_i (
        .clk32      (clk32),      .porb      (porb),
        .bus_i      (bus_i),      .mfpint_n_i (mfpint_n_i),
        .rdata_o    (rdata_o),    .oe_h_n_o  (oe_h_n_o),
        .dtack_n_o  (dtack_n_o),  .vpa_n_o   (vpa_n_o),
        .ipl1_n_o   (ipl1_n_o),   .ipl2_n_o  (ipl2_n_o),
        .hsync_n_o  (hsync_n_o),  .vsync_n_o (vsync_n_o),
        .de_o       (de_o),       .blank_n_o (blank_n_o)
    );

    always #4 clk32 = ~clk32;

    // DE stays low through both sync pulses
    assert property (@(posedge clk32) disable iff (!porb)
                     !(de_o && (!hsync_n_o || !vsync_n_o)))
    else stop_on_error("de_o was high while a sync pulse was active");

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp)
        else stop_on_error($sformatf("[ERROR] %0t ns %s expected %b got %b",
                                     $time, name, exp, act));
    endtask

    task automatic check_num(input string name, input int exp, input int act);
        assert (act == exp)
        else stop_on_error($sformatf("[ERROR] %0t ns %s expected %0d (%h) got %0d (%h)",
                                     $time, name, exp, exp, act, act));
    endtask

    initial begin
        logic [15:0] wdata, rdata;
        logic [2:0]  fc;
        logic        oe_n, dtack_n, vpa_n;
        int          low, period, cnt;

        void'($urandom(32'h1089cb59));
        clk32      = 1'b0;
        porb       = 1'b0;
        mfpint_n_i = 1'b1;
        release_bus();

        // ==================================================================
        // Reset state
        // ==================================================================
        repeat (2) @(posedge clk32);
        @(negedge clk32);
        check_bit("dtack_n_o", 1'b1, dtack_n_o);
        check_bit("vpa_n_o", 1'b1, vpa_n_o);
        check_bit("oe_h_n_o", 1'b1, oe_h_n_o);
        check_bit("ipl1_n_o", 1'b1, ipl1_n_o);
        check_bit("ipl2_n_o", 1'b1, ipl2_n_o);
        check_bit("hsync_n_o", 1'b1, hsync_n_o);
        check_bit("vsync_n_o", 1'b1, vsync_n_o);
        check_bit("de_o", 1'b1, de_o);
        check_bit("blank_n_o", 1'b1, blank_n_o);
        @(posedge clk32);
        porb <= 1'b1;
        cpu_read(3'd5, ADDR_SYNC_REG, rdata, oe_n, dtack_n);
        check_num("rdata_o", 32'h0000FCFF, int'(rdata));   // PAL bit clear
        check_bit("oe_h_n_o", 1'b0, oe_n);
        check_bit("dtack_n_o", 1'b0, dtack_n);

        // Sync register readback, bit 9 only
        for (int i = 0; i < 6; i++) begin
            wdata    = 16'($urandom);
            wdata[9] = i[0];                                // Both PAL values
            fc       = ($urandom_range(0, 1) == 0) ? 3'd5 : 3'd6;
            cpu_write(fc, ADDR_SYNC_REG, wdata, dtack_n);
            check_bit("dtack_n_o", 1'b0, dtack_n);
            repeat ($urandom_range(0, 3)) @(posedge clk32);
            cpu_read(fc, ADDR_SYNC_REG, rdata, oe_n, dtack_n);
            check_num("rdata_o", int'({6'h3F, wdata[9], 1'b0, 8'hFF}), int'(rdata));
            check_bit("oe_h_n_o", 1'b0, oe_n);
        end
        cpu_write(3'd5, ADDR_MODE_REG, 16'h0000, dtack_n);
        check_bit("dtack_n_o", 1'b1, dtack_n);             // Owner is elsewhere
        cpu_write(3'd5, ADDR_SYNC_REG, 16'h0000, dtack_n);
        cpu_write(3'd1, ADDR_SYNC_REG, 16'h0200, dtack_n); // User data space
        check_bit("dtack_n_o", 1'b1, dtack_n);
        cpu_read(3'd5, ADDR_SYNC_REG, rdata, oe_n, dtack_n);
        check_num("rdata_o", 32'h0000FCFF, int'(rdata));

        // ==================================================================
        // Horizontal timing, NTSC then PAL then mono
        // ==================================================================
        measure_sync(1'b0, HSYNC_LIMIT, low, period);
        check_num("hsync_n_o period", LINE_NTSC, period);
        check_num("hsync_n_o low", 160, low);
        cpu_write(3'd5, ADDR_SYNC_REG, 16'h0200, dtack_n);
        measure_sync(1'b0, HSYNC_LIMIT, low, period);
        check_num("hsync_n_o period", LINE_PAL, period);
        check_num("hsync_n_o low", 160, low);
        cpu_write(3'd5, ADDR_MODE_REG, 16'h0200, dtack_n);
        measure_sync(1'b0, HSYNC_LIMIT, low, period);
        check_num("hsync_n_o period", LINE_MONO, period);
        check_num("hsync_n_o low", 96, low);

        // Vertical, 501 lines per mono frame
        measure_sync(1'b1, VSYNC_LIMIT, low, period);
        check_num("vsync_n_o period", 501 * LINE_MONO, period);
        check_num("vsync_n_o low", 2 * LINE_MONO, low);
        cpu_write(3'd5, ADDR_MODE_REG, 16'h0000, dtack_n);
        measure_sync(1'b1, VSYNC_LIMIT, low, period);
        check_num("vsync_n_o low", 4 * LINE_PAL, low);

        // ==================================================================
        // Interrupts
        // ==================================================================
        wait_sync(1'b1, 1'b1, VSYNC_LIMIT, cnt);
        repeat (2) @(negedge clk32);
        check_bit("ipl2_n_o", 1'b0, ipl2_n_o);
        check_bit("ipl1_n_o", 1'b1, ipl1_n_o);             // VBL masks HBL
        int_ack(IACK_VBL, vpa_n);
        check_bit("vpa_n_o", 1'b0, vpa_n);
        @(negedge clk32);
        check_bit("ipl2_n_o", 1'b1, ipl2_n_o);
        check_bit("ipl1_n_o", 1'b0, ipl1_n_o);             // HBL still pending
        wait_sync(1'b0, 1'b0, HSYNC_LIMIT, cnt);
        wait_sync(1'b0, 1'b1, HSYNC_LIMIT, cnt);
        repeat (3) @(negedge clk32);
        int_ack(IACK_HBL, vpa_n);
        check_bit("vpa_n_o", 1'b0, vpa_n);
        @(negedge clk32);
        check_bit("ipl1_n_o", 1'b1, ipl1_n_o);
        check_bit("ipl2_n_o", 1'b1, ipl2_n_o);
        @(posedge clk32);
        mfpint_n_i <= 1'b0;
        @(negedge clk32);
        check_bit("ipl1_n_o", 1'b0, ipl1_n_o);             // Level 6
        check_bit("ipl2_n_o", 1'b0, ipl2_n_o);
        @(posedge clk32);
        mfpint_n_i <= 1'b1;
        wait_sync(1'b0, 1'b0, HSYNC_LIMIT, cnt);
        wait_sync(1'b0, 1'b1, HSYNC_LIMIT, cnt);
        repeat (2) @(negedge clk32);
        check_bit("ipl1_n_o", 1'b0, ipl1_n_o);
        check_bit("ipl2_n_o", 1'b1, ipl2_n_o);

        $display("Everything OK");
        $finish;
    end

`include "tb_bus_tasks.svh"

endmodule

`default_nettype wire

// File: stmcu_video.sv
/*
 * STe video timing block, top level
 *  - Tick enables, register decode, sync generators
 *  - Display enable and interrupt logic
 */
`timescale 1ns/100ps
`default_nettype none

module stmcu_video #(
    parameter int TICK_DIV = 16
) (
    input  logic                      clk32,
    input  logic                      porb,
    input  stmcu_video_pkg::cpu_bus_t bus_i,
    input  logic                      mfpint_n_i,
    output logic [15:0]               rdata_o,
    output logic                      oe_h_n_o,
    output logic                      dtack_n_o,
    output logic                      vpa_n_o,
    output logic                      ipl1_n_o,
    output logic                      ipl2_n_o,
    output logic                      hsync_n_o,
    output logic                      vsync_n_o,
    output logic                      de_o,
    output logic                      blank_n_o
);

    import stmcu_video_pkg::*;

    logic        tick_p;
    logic        tick_n;
    video_mode_t mode;
    logic        hbl_ack;
    logic        vbl_ack;
    logic        line_tick;
    logic        vert_tick;

    mcu_clock_enables #(
        .TICK_DIV (TICK_DIV)
    ) u_clk_en (
        .clk32    (clk32),
        .porb     (porb),
        .tick_p_o (tick_p),
        .tick_n_o (tick_n)
    );

    video_regs u_regs (
        .clk32     (clk32),
        .porb      (porb),
        .bus_i     (bus_i),
        .mode_o    (mode),
        .rdata_o   (rdata_o),
        .oe_h_n_o  (oe_h_n_o),
        .dtack_n_o (dtack_n_o),
        .vpa_n_o   (vpa_n_o),
        .hbl_ack_o (hbl_ack),
        .vbl_ack_o (vbl_ack)
    );

    hsync_gen u_hsync (
        .clk32       (clk32),
        .porb        (porb),
        .tick_p_i    (tick_p),
        .mode_i      (mode),
        .hsync_n_o   (hsync_n_o),
        .line_tick_o (line_tick),
        .vert_tick_o (vert_tick)
    );

    vsync_gen u_vsync (
        .clk32       (clk32),
        .porb        (porb),
        .vert_tick_i (vert_tick),
        .mode_i      (mode),
        .vsync_n_o   (vsync_n_o)
    );

    de_gen u_de (
        .clk32       (clk32),
        .porb        (porb),
        .tick_p_i    (tick_p),
        .tick_n_i    (tick_n),
        .mode_i      (mode),
        .hsync_n_i   (hsync_n_o),
        .vsync_n_i   (vsync_n_o),
        .line_tick_i (line_tick),
        .de_o        (de_o),
        .blank_n_o   (blank_n_o)
    );

    vid_interrupts u_irq (
        .clk32      (clk32),
        .porb       (porb),
        .hsync_n_i  (hsync_n_o),
        .vsync_n_i  (vsync_n_o),
        .hbl_ack_i  (hbl_ack),
        .vbl_ack_i  (vbl_ack),
        .mfpint_n_i (mfpint_n_i),
        .ipl1_n_o   (ipl1_n_o),
        .ipl2_n_o   (ipl2_n_o)
    );

endmodule

`default_nettype wire

// File: vid_interrupts.sv
/*
 * HBL and VBL interrupt latches
 *  - Set on the rising edge of each sync
 *  - Cleared by the matching acknowledge
 *  - Priority encoding with the MFP request
 */
`timescale 1ns/100ps
`default_nettype none

module vid_interrupts (
    input  logic clk32,
    input  logic porb,
    input  logic hsync_n_i,
    input  logic vsync_n_i,
    input  logic hbl_ack_i,
    input  logic vbl_ack_i,
    input  logic mfpint_n_i,
    output logic ipl1_n_o,
    output logic ipl2_n_o
);

    logic hsync_n_d;
    logic vsync_n_d;
    logic hbl_pend;
    logic vbl_pend;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsync_n_d <= 1'b1;
            vsync_n_d <= 1'b1;
            hbl_pend  <= 1'b0;
            vbl_pend  <= 1'b0;
        end else begin
            hsync_n_d <= hsync_n_i;
            vsync_n_d <= vsync_n_i;
            if (hbl_ack_i)                   hbl_pend <= 1'b0;   // Ack wins
            else if (hsync_n_i && !hsync_n_d) hbl_pend <= 1'b1;
            if (vbl_ack_i)                   vbl_pend <= 1'b0;
            else if (vsync_n_i && !vsync_n_d) vbl_pend <= 1'b1;
        end
    end

    // Level 2 HBL, level 4 VBL, level 6 MFP
    assign ipl1_n_o = mfpint_n_i & (~hbl_pend | vbl_pend);
    assign ipl2_n_o = mfpint_n_i & ~vbl_pend;

endmodule

`default_nettype wire

// File: de_gen.sv
/*
 * Display enable and blanking generator
 *  - Horizontal DE counter restarted by each hsync
 *  - Vertical DE counter restarted by each vsync
 *  - DE and BLANK registered on the 2 MHz tick
 */
`timescale 1ns/100ps
`default_nettype none

module de_gen (
    input  logic                         clk32,
    input  logic                         porb,
    input  logic                         tick_p_i,
    input  logic                         tick_n_i,
    input  stmcu_video_pkg::video_mode_t mode_i,
    input  logic                         hsync_n_i,
    input  logic                         vsync_n_i,
    input  logic                         line_tick_i,
    output logic                         de_o,
    output logic                         blank_n_o
);

    import stmcu_video_pkg::*;

    logic      cpal;
    logic      cntsc;
    hdecount_t hdec;
    logic      hblank_n;                   // High while the line is visible
    logic      hde;
    logic      hde_set_d1;
    logic      hde_set_d2;
    logic      hblank_set, hblank_res;
    logic      hde_set, hde_res;
    vcount_t   vdec;
    logic      vblank_n;
    logic      vde;
    logic      vblank_set, vblank_res;
    logic      vde_set, vde_res;

    assign cpal  = ~mode_i.mono & ~mode_i.ntsc;
    assign cntsc = ~mode_i.mono &  mode_i.ntsc;

    // ======================================================================
    // Horizontal
    // ======================================================================
    assign hblank_set = (cntsc & hdec == 8'd8) | (cpal & hdec == 8'd9);
    assign hblank_res = mode_i.mono | hdec == 8'd114;
    assign hde_set    = (cntsc & hdec == 8'd11) | (cpal & hdec == 8'd12) |
                        (mode_i.mono & hdec == 8'd2);
    assign hde_res    = (cntsc & hdec == 8'd95) | (cpal & hdec == 8'd96) |
                        (mode_i.mono & hdec == 8'd43);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hdec       <= '0;
            hblank_n   <= 1'b0;
            hde        <= 1'b0;
            hde_set_d1 <= 1'b0;
            hde_set_d2 <= 1'b0;
        end else if (!hsync_n_i) begin   // Held clear for the whole hsync
            hdec       <= '0;
            hblank_n   <= 1'b0;
            hde        <= 1'b0;
            hde_set_d1 <= 1'b0;
            hde_set_d2 <= 1'b0;
        end else if (tick_n_i) begin
            hdec <= hdec + 1'b1;
            if (hblank_set) hblank_n <= 1'b1;
            if (hblank_res) hblank_n <= 1'b0;
            hde_set_d1 <= hde_set;
            hde_set_d2 <= hde_set_d1;
            // Medium res starts DE two ticks later
            if (hde_res)                                   hde <= 1'b0;
            else if (mode_i.mde0 ? hde_set_d2 : hde_set)   hde <= 1'b1;
        end
    end

    // ======================================================================
    // Vertical
    // ======================================================================
    assign vblank_set = (cpal & vdec == 9'd24) | (cntsc & vdec == 9'd15);
    assign vblank_res = mode_i.mono | (cpal & vdec == 9'd307) | (cntsc & vdec == 9'd257);
    assign vde_set    = (mode_i.mono & vdec == 9'd35) | (cpal & vdec == 9'd62) |
                        (cntsc & vdec == 9'd33);
    assign vde_res    = (mode_i.mono & vdec == 9'd435) | (cpal & vdec == 9'd262) |
                        (cntsc & vdec == 9'd233);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vdec     <= '0;
            vde      <= 1'b0;
            vblank_n <= 1'b0;
        end else if (!vsync_n_i) begin
            vdec     <= '0;
            vde      <= 1'b0;
            vblank_n <= 1'b0;
        end else if (line_tick_i) begin   // One count per line at hsync end
            vdec <= vdec + 1'b1;
            if (vde_set)    vde <= 1'b1;
            if (vde_res)    vde <= 1'b0;
            if (vblank_set) vblank_n <= 1'b1;
            if (vblank_res) vblank_n <= 1'b0;
        end
    end

    // Outputs
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            de_o      <= 1'b1;
            blank_n_o <= 1'b1;
        end else if (tick_p_i) begin
            de_o      <= hde & vde;
            blank_n_o <= hblank_n & vblank_n;
        end
    end

endmodule

`default_nettype wire

// File: vsync_gen.sv
/*
 * Vertical sync generator
 *  - Line counter clocked by the vertical tick
 *  - Double reload at line 511 to the mode's start line
 *  - Vertical sync from the sync line up to the second reload
 */
`timescale 1ns/100ps
`default_nettype none

module vsync_gen (
    input  logic                         clk32,
    input  logic                         porb,
    input  logic                         vert_tick_i,
    input  stmcu_video_pkg::video_mode_t mode_i,
    output logic                         vsync_n_o
);

    import stmcu_video_pkg::*;

    vcount_t vsc;
    vcount_t vsc_load_val;
    vcount_t vsync_set;
    logic    vsc_load;

    // 200 / 250 / 12 give 313, 263 and 501 lines per frame
    always_comb begin
        if (mode_i.mono)      vsc_load_val = 9'd12;
        else if (mode_i.ntsc) vsc_load_val = 9'd250;
        else                  vsc_load_val = 9'd200;
    end

    assign vsync_set = mode_i.mono ? 9'd510 : 9'd508;

    // ======================================================================
    // Line counter
    // ======================================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vsc       <= '0;
            vsc_load  <= 1'b1;             // First line tick loads the counter
            vsync_n_o <= 1'b1;
        end else if (vert_tick_i) begin
            vsc <= vsc + 1'b1;
            // The second load picks up a mode written after the first one
            if (vsc == 9'd511 || vsc_load) begin
                vsc_load <= ~vsc_load;
                vsc      <= vsc_load_val;
            end
            if (vsc_load)         vsync_n_o <= 1'b1;   // Sync ends at the second load
            if (vsc == vsync_set) vsync_n_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hsync_gen.sv
/*
 * Horizontal sync generator
 *  - Position counter with the STe double reload at 127
 *  - Horizontal sync at the mode's positions
 *  - Line end and vertical clock ticks
 */
`timescale 1ns/100ps
`default_nettype none

module hsync_gen (
    input  logic                         clk32,
    input  logic                         porb,
    input  logic                         tick_p_i,
    input  stmcu_video_pkg::video_mode_t mode_i,
    output logic                         hsync_n_o,
    output logic                         line_tick_o,
    output logic                         vert_tick_o
);

    import stmcu_video_pkg::*;

    hcount_t hsc;
    hcount_t hsc_load_val;
    hcount_t hsync_set;
    hcount_t hsync_res;
    logic    hsc_load;                     // Second reload pending

    // Load values 1 / 2 / 73 give 128, 127 and 56 ticks per line
    always_comb begin
        if (mode_i.mono)      hsc_load_val = 7'd73;
        else if (mode_i.ntsc) hsc_load_val = 7'd2;
        else                  hsc_load_val = 7'd1;
    end

    assign hsync_set = mode_i.mono ? 7'd121 : 7'd101;
    assign hsync_res = mode_i.mono ? 7'd127 : 7'd111;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsc       <= '0;
            hsc_load  <= 1'b0;
            hsync_n_o <= 1'b1;
        end else if (tick_p_i) begin
            hsc <= hsc + 1'b1;
            if (hsc == 7'd127 || hsc_load) begin
                hsc_load <= ~hsc_load;
                hsc      <= hsc_load_val;  // Mode can change between both loads
            end
            if (hsc == hsync_set) hsync_n_o <= 1'b0;
            if (hsc == hsync_res) hsync_n_o <= 1'b1;
        end
    end

    assign line_tick_o = tick_p_i & (hsc == hsync_res);
    assign vert_tick_o = tick_p_i & hsc_load;        // Tick of the second reload

endmodule

`default_nettype wire

// File: video_regs.sv
/*
 * CPU register decode for the video timing block
 *  - Mode register FF8260 (write only) and sync register FF820A
 *  - Readback byte, output enable and DTACK
 *  - HBL and VBL interrupt acknowledge with VPA
 */
`timescale 1ns/100ps
`default_nettype none

module video_regs (
    input  logic                         clk32,
    input  logic                         porb,
    input  stmcu_video_pkg::cpu_bus_t    bus_i,
    output stmcu_video_pkg::video_mode_t mode_o,
    output logic [15:0]                  rdata_o,
    output logic                         oe_h_n_o,
    output logic                         dtack_n_o,
    output logic                         vpa_n_o,
    output logic                         hbl_ack_o,
    output logic                         vbl_ack_o
);

    import stmcu_video_pkg::*;

    logic       ias;
    logic       iuds;
    logic       fc_dev;
    logic       idev;
    logic       iack;
    logic       mode_sel;
    logic       sync_sel;
    logic       sync_rd;
    logic       mono;
    logic       mde0;
    logic       pal;
    logic [1:0] rd_hi;

    // ======================================================================
    // Cycle decode
    // ======================================================================
    assign ias    = ~bus_i.as_n;
    assign iuds   = ~bus_i.uds_n;
    assign fc_dev = bus_i.fc[2] & (bus_i.fc[0] ^ bus_i.fc[1]);   // FC 5 or 6
    assign idev   = fc_dev & ias & iuds & (bus_i.addr[23:16] == 8'hFF);
    assign iack   = ias & (bus_i.fc == FC_IACK);

    assign mode_sel = idev & (bus_i.addr[15:1] == ADDR_MODE_REG[15:1]);
    assign sync_sel = idev & (bus_i.addr[15:1] == ADDR_SYNC_REG[15:1]);
    assign sync_rd  = sync_sel & bus_i.rw;

    // Mode and PAL flip-flops, upper byte only
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            mono <= 1'b0;
            mde0 <= 1'b0;
            pal  <= 1'b0;                  // NTSC after power-on
        end else begin
            if (mode_sel && !bus_i.rw) begin
                mono <= bus_i.wdata[9];
                mde0 <= bus_i.wdata[8];
            end
            if (sync_sel && !bus_i.rw) pal <= bus_i.wdata[9];
        end
    end

    assign mode_o = '{mono: mono, mde0: mde0, ntsc: ~pal};

    // Readback of the sync register
    assign rd_hi    = sync_rd ? {pal, 1'b0} : 2'b11;
    assign rdata_o  = {6'b111111, rd_hi, 8'hFF};
    assign oe_h_n_o = ~sync_rd;

    // Mode register is acknowledged by its owner outside this block
    assign dtack_n_o = ~sync_sel;

    // Autovectored HBL and VBL acknowledge
    assign hbl_ack_o = iack & (bus_i.addr[3:1] == IACK_HBL);
    assign vbl_ack_o = iack & (bus_i.addr[3:1] == IACK_VBL);
    assign vpa_n_o   = ~(hbl_ack_o | vbl_ack_o);

endmodule

`default_nettype wire

// File: mcu_clock_enables.sv
/*
 * 2 MHz tick enables derived from clk32
 *  - tick_p at phase zero, tick_n halfway between two tick_p pulses
 */
`timescale 1ns/100ps
`default_nettype none

module mcu_clock_enables #(
    parameter int TICK_DIV = 16             // clk32 cycles per tick
) (
    input  logic clk32,
    input  logic porb,
    output logic tick_p_o,
    output logic tick_n_o
);

    localparam int PW = $clog2(TICK_DIV);

    logic [PW-1:0] phase;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            phase    <= '0;
            tick_p_o <= 1'b0;
            tick_n_o <= 1'b0;
        end else begin
            if (phase == PW'(TICK_DIV - 1)) phase <= '0;
            else                            phase <= phase + 1'b1;
            tick_p_o <= (phase == PW'(TICK_DIV - 1));      // High while phase is zero
            tick_n_o <= (phase == PW'(TICK_DIV / 2 - 1));  // Half phase
        end
    end

endmodule

`default_nettype wire

// File: stmcu_video_pkg.sv
/*
 * Shared types and constants for the STe video timing block
 *  - CPU bus and display mode structs
 *  - Counter widths for the sync and display enable generators
 *  - Register word addresses and interrupt acknowledge codes
 */
`default_nettype none

package stmcu_video_pkg;

    // ======================================================================
    // CPU bus as seen by the chip
    // ======================================================================
    typedef struct packed {
        logic        as_n;
        logic        rw;          // 1 = read
        logic        uds_n;
        logic        lds_n;
        logic [2:0]  fc;          // FC2..FC0
        logic [23:1] addr;        // Word address A23..A1
        logic [15:0] wdata;
    } cpu_bus_t;

    // Current display mode
    typedef struct packed {
        logic mono;               // Mode bit 1
        logic mde0;               // Mode bit 0
        logic ntsc;               // Inverse of the PAL bit
    } video_mode_t;

    // ======================================================================
    // Counter widths
    // ======================================================================
    typedef logic [6:0] hcount_t;     // Horizontal position in 2 MHz ticks
    typedef logic [8:0] vcount_t;     // Line counter
    typedef logic [7:0] hdecount_t;   // Horizontal DE position

    // Register word addresses
    localparam logic [23:1] ADDR_MODE_REG = 23'h7FC130;   // FF8260
    localparam logic [23:1] ADDR_SYNC_REG = 23'h7FC105;   // FF820A

    // Interrupt acknowledge
    localparam logic [2:0] FC_IACK  = 3'b111;
    localparam logic [2:0] IACK_HBL = 3'd2;   // Level code on A3..A1
    localparam logic [2:0] IACK_VBL = 3'd4;

endpackage

`default_nettype wire
